//--- build.f
+incdir+design
design/ob_pkg.sv
design/ob_cmd_latch.sv
design/ob_book_table.sv
design/ob_match.sv
design/ob_cntrl_fsm.sv
design/ob_rsp_fifo.sv
design/ob_top.sv
tb/tb_ob_top.sv

//--- Bender.yml
package:
  name: order_book

export_include_dirs:
  - design

sources:
  - files:
      - design/ob_pkg.sv
      - design/ob_cmd_latch.sv
      - design/ob_book_table.sv
      - design/ob_match.sv
      - design/ob_cntrl_fsm.sv
      - design/ob_rsp_fifo.sv
      - design/ob_top.sv
  - target: test
    files:
      - tb/tb_ob_top.sv

//--- tb/tb_ob_top.sv
// Order book testbench with command table, reference books and random egress stalls
`timescale 1ns/100ps
`include "ob_config.svh"

module tb_ob_top;

  import ob_pkg::*;

  typedef enum int {CHK_PLAIN, CHK_SPREAD, CHK_TRADE, CHK_POPTOP} chk_kind_e;

  localparam int N_CMDS          = 27;
  localparam int WATCHDOG_CYCLES = N_CMDS * 60;

  // opcode, uid, price, quantity, cancel_uid
  localparam ob_cmd_t CMD_TABLE [N_CMDS] = '{
    '{OP_NOP,         8'h01, 16'd0,   12'd0,   8'h00},
    '{OP_QRY_BID_ASK, 8'h02, 16'd0,   12'd0,   8'h00},
    '{OP_BUY_LIMIT,   8'h10, 16'd100, 12'd50,  8'h00},
    '{OP_SELL_LIMIT,  8'h20, 16'd105, 12'd40,  8'h00},
    '{OP_QRY_BID_ASK, 8'h03, 16'd0,   12'd0,   8'h00},
    '{OP_SELL_LIMIT,  8'h21, 16'd106, 12'd30,  8'h00},
    // Sweeps both asks and rests with the rest
    '{OP_BUY_LIMIT,   8'h11, 16'd107, 12'd100, 8'h00},
    '{OP_POP_TOP_BID, 8'h04, 16'd0,   12'd0,   8'h00},
    '{OP_POP_TOP_BID, 8'h05, 16'd0,   12'd0,   8'h00},
    '{OP_POP_TOP_BID, 8'h06, 16'd0,   12'd0,   8'h00},
    '{OP_POP_TOP_ASK, 8'h07, 16'd0,   12'd0,   8'h00},
    // Fill the bid book, one price tie included
    '{OP_BUY_LIMIT,   8'h12, 16'd90,  12'd10,  8'h00},
    '{OP_BUY_LIMIT,   8'h13, 16'd95,  12'd10,  8'h00},
    '{OP_BUY_LIMIT,   8'h14, 16'd90,  12'd20,  8'h00},
    '{OP_BUY_LIMIT,   8'h15, 16'd80,  12'd5,   8'h00},
    '{OP_BUY_LIMIT,   8'h16, 16'd99,  12'd5,   8'h00},
    '{OP_CANCEL,      8'h08, 16'd0,   12'd0,   8'h13},
    '{OP_CANCEL,      8'h09, 16'd0,   12'd0,   8'h77},
    '{OP_SELL_LIMIT,  8'h22, 16'd90,  12'd25,  8'h00},
    '{OP_POP_TOP_BID, 8'h0a, 16'd0,   12'd0,   8'h00},
    '{OP_SELL_LIMIT,  8'h23, 16'd80,  12'd5,   8'h00},
    '{OP_QRY_BID_ASK, 8'h0b, 16'd0,   12'd0,   8'h00},
    '{OP_NOP,         8'h0c, 16'd0,   12'd0,   8'h00},
    '{OP_SELL_LIMIT,  8'h24, 16'd110, 12'd7,   8'h00},
    '{OP_SELL_LIMIT,  8'h25, 16'd108, 12'd3,   8'h00},
    '{OP_BUY_LIMIT,   8'h17, 16'd120, 12'd10,  8'h00},
    '{OP_POP_TOP_ASK, 8'h0d, 16'd0,   12'd0,   8'h00}
  };

  logic        clk;
  logic        rst_n;
  logic        cmd_vld;
  ob_cmd_t     cmd;
  logic        cmd_pop;
  logic        rsp_vld;
  ob_rsp_t     rsp;
  logic        rsp_pop;

  // Reference books, best first
  ob_entry_t   bid_q [$];
  ob_entry_t   ask_q [$];
  ob_rsp_t     exp_q [$];
  chk_kind_e   kind_q [$];
  int          n_checked;
  logic [31:0] rng;

  ob_top u_dut (
      .clk     (clk)
    , .rst_n   (rst_n)
    , .cmd_vld (cmd_vld)
    , .cmd     (cmd)
    , .cmd_pop (cmd_pop)
    , .rsp_vld (rsp_vld)
    , .rsp     (rsp)
    , .rsp_pop (rsp_pop)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_mismatch(input string field, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAIL %0t: %s got %0h expected %0h", $time, field, got, exp);
    $display("=== FAIL ===");
    $fatal(1, "response mismatch");
  endtask

  task automatic check_rsp(input ob_rsp_t got, input ob_rsp_t exp, input bit spread);
    if (got.uid !== exp.uid) report_mismatch("uid", got.uid, exp.uid);
    if (got.status !== exp.status) report_mismatch("status", got.status, exp.status);
    // Spread read through the union
    if (spread) begin
      if (got.result.qrybidask.body.bid !== exp.result.qrybidask.body.bid)
        report_mismatch("spread bid", got.result.qrybidask.body.bid,
                        exp.result.qrybidask.body.bid);
      if (got.result.qrybidask.body.ask !== exp.result.qrybidask.body.ask)
        report_mismatch("spread ask", got.result.qrybidask.body.ask,
                        exp.result.qrybidask.body.ask);
    end
  endtask

  task automatic check_trade(input ob_trade_t got, input ob_trade_t exp);
    if (got.bid_uid !== exp.bid_uid) report_mismatch("trade bid_uid", got.bid_uid, exp.bid_uid);
    if (got.ask_uid !== exp.ask_uid) report_mismatch("trade ask_uid", got.ask_uid, exp.ask_uid);
    if (got.quantity !== exp.quantity)
      report_mismatch("trade quantity", got.quantity, exp.quantity);
  endtask

  task automatic check_poptop(input ob_poptop_t got, input ob_poptop_t exp);
    if (got.uid !== exp.uid) report_mismatch("poptop uid", got.uid, exp.uid);
    if (got.price !== exp.price) report_mismatch("poptop price", got.price, exp.price);
    if (got.quantity !== exp.quantity)
      report_mismatch("poptop quantity", got.quantity, exp.quantity);
  endtask

  task automatic expect_rsp(input ob_rsp_t r, input chk_kind_e k);
    exp_q.push_back(r);
    kind_q.push_back(k);
  endtask

  // Strictly better price goes ahead, ties queue behind
  task automatic insert_order(input bit bid_side, input ob_entry_t e);
    int pos;
    bit found;
    found = 1'b0;
    if (bid_side) begin
      pos = bid_q.size();
      for (int i = 0; i < bid_q.size(); i++)
        if (!found && e.price > bid_q[i].price) begin
          pos   = i;
          found = 1'b1;
        end
      bid_q.insert(pos, e);
    end else begin
      pos = ask_q.size();
      for (int i = 0; i < ask_q.size(); i++)
        if (!found && e.price < ask_q[i].price) begin
          pos   = i;
          found = 1'b1;
        end
      ask_q.insert(pos, e);
    end
  endtask

  // One trade per cross until the heads no longer meet
  task automatic run_matching();
    ob_rsp_t r;
    while (bid_q.size() > 0 && ask_q.size() > 0 && bid_q[0].price >= ask_q[0].price) begin
      r                            = '0;
      r.uid                        = '1;
      r.status                     = ST_OKAY;
      r.result.trade.body.bid_uid  = bid_q[0].uid;
      r.result.trade.body.ask_uid  = ask_q[0].uid;
      if (bid_q[0].quantity < ask_q[0].quantity) begin
        r.result.trade.body.quantity = bid_q[0].quantity;
        ask_q[0].quantity            = ask_q[0].quantity - bid_q[0].quantity;
        void'(bid_q.pop_front());
      end else if (ask_q[0].quantity < bid_q[0].quantity) begin
        r.result.trade.body.quantity = ask_q[0].quantity;
        bid_q[0].quantity            = bid_q[0].quantity - ask_q[0].quantity;
        void'(ask_q.pop_front());
      end else begin
        r.result.trade.body.quantity = bid_q[0].quantity;
        void'(bid_q.pop_front());
        void'(ask_q.pop_front());
      end
      expect_rsp(r, CHK_TRADE);
    end
  endtask

  task automatic predict(input ob_cmd_t c);
    ob_rsp_t   r;
    ob_entry_t e;
    bit        hit;
    r        = '0;
    r.uid    = c.uid;
    r.status = ST_OKAY;
    e.uid      = c.uid;
    e.price    = c.price;
    e.quantity = c.quantity;
    hit        = 1'b0;
    case (c.opcode)
      OP_NOP: expect_rsp(r, CHK_PLAIN);
      OP_QRY_BID_ASK: begin
        if (bid_q.size() > 0 && ask_q.size() > 0) begin
          r.result.qrybidask.body.bid = bid_q[0].price;
          r.result.qrybidask.body.ask = ask_q[0].price;
          expect_rsp(r, CHK_SPREAD);
        end else begin
          r.status = ST_BAD;
          expect_rsp(r, CHK_PLAIN);
        end
      end
      OP_BUY_LIMIT, OP_SELL_LIMIT: begin
        if ((c.opcode == OP_BUY_LIMIT ? bid_q.size() : ask_q.size()) == `OB_BOOK_DEPTH) begin
          r.status = ST_REJECT;
          expect_rsp(r, CHK_PLAIN);
        end else begin
          expect_rsp(r, CHK_PLAIN);
          insert_order(c.opcode == OP_BUY_LIMIT, e);
          run_matching();
        end
      end
      OP_POP_TOP_BID: begin
        if (bid_q.size() > 0) r.result.poptop = bid_q.pop_front();
        else r.status = ST_BAD_POP;
        expect_rsp(r, CHK_POPTOP);
      end
      OP_POP_TOP_ASK: begin
        if (ask_q.size() > 0) r.result.poptop = ask_q.pop_front();
        else r.status = ST_BAD_POP;
        expect_rsp(r, CHK_POPTOP);
      end
      OP_CANCEL: begin
        // Either side may hold the uid
        for (int i = bid_q.size() - 1; i >= 0; i--)
          if (bid_q[i].uid == c.cancel_uid) begin
            bid_q.delete(i);
            hit = 1'b1;
          end
        for (int i = ask_q.size() - 1; i >= 0; i--)
          if (ask_q[i].uid == c.cancel_uid) begin
            ask_q.delete(i);
            hit = 1'b1;
          end
        r.status = hit ? ST_CANCEL_HIT : ST_CANCEL_MISS;
        expect_rsp(r, CHK_PLAIN);
      end
      default: ;
    endcase
  endtask

  task automatic compare_head();
    ob_rsp_t   exp;
    chk_kind_e kind;
    if (exp_q.size() == 0) begin
      $display("Response arrived at %0t with no prediction left", $time);
      $display("=== FAIL ===");
      $fatal(1, "unexpected response");
    end
    exp  = exp_q.pop_front();
    kind = kind_q.pop_front();
    check_rsp(rsp, exp, kind == CHK_SPREAD);
    if (kind == CHK_TRADE) check_trade(rsp.result.trade.body, exp.result.trade.body);
    if (kind == CHK_POPTOP) check_poptop(rsp.result.poptop, exp.result.poptop);
    n_checked++;
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_vld   = 1'b0;
    cmd       = '0;
    rsp_pop   = 1'b0;
    n_checked = 0;
    rng       = 32'h993d6bb5;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < N_CMDS; i++) begin
      predict(CMD_TABLE[i]);
      cmd_vld = 1'b1;
      cmd     = CMD_TABLE[i];
      // Taken on the edge after cmd_pop is seen
      do @(negedge clk); while (!cmd_pop);
      @(posedge clk);
      #1;
    end
    cmd_vld = 1'b0;
    cmd     = '0;
    while (exp_q.size() != 0) @(negedge clk);
    // Quiet period, nothing further may appear
    repeat (10) @(negedge clk);
    if (rsp_vld) begin
      $display("Extra response left in the egress queue at %0t", $time);
      $display("=== FAIL ===");
      $fatal(1, "extra response");
    end else begin
      $display("Checked %0d responses", n_checked);
      $display("=== PASS ===");
      $finish;
    end
  end

  // Egress drain with random stalls for back-pressure
  initial begin
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      #1;
      rng     = next_rand(rng);
      rsp_pop = (rng[1:0] == 2'b00);
      @(negedge clk);
      if (rsp_vld && rsp_pop) compare_head();
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- design/ob_top.sv
// Order book top level joining command latch, books, match stage, controller and egress
`timescale 1ns/100ps
`include "ob_config.svh"

module ob_top (
    input  logic            clk
  , input  logic            rst_n
  , input  logic            cmd_vld
  , input  ob_pkg::ob_cmd_t cmd
  , output logic            cmd_pop
  , output logic            rsp_vld
  , output ob_pkg::ob_rsp_t rsp
  , input  logic            rsp_pop
);

  // Latch to controller
  logic                 latch_vld;
  ob_pkg::ob_cmd_t      latch;
  logic                 consume;

  // Bid book strobes and state
  logic                 bid_insert;
  ob_pkg::ob_entry_t    bid_insert_entry;
  logic                 bid_pop;
  logic                 bid_update;
  logic [`OB_QTY_W-1:0] bid_update_qty;
  logic                 bid_cancel;
  logic [`OB_UID_W-1:0] bid_cancel_uid;
  logic                 bid_head_vld;
  ob_pkg::ob_entry_t    bid_head;
  logic                 bid_full;
  logic                 bid_cancel_hit;

  // Ask book strobes and state
  logic                 ask_insert;
  ob_pkg::ob_entry_t    ask_insert_entry;
  logic                 ask_pop;
  logic                 ask_update;
  logic [`OB_QTY_W-1:0] ask_update_qty;
  logic                 ask_cancel;
  logic [`OB_UID_W-1:0] ask_cancel_uid;
  logic                 ask_head_vld;
  ob_pkg::ob_entry_t    ask_head;
  logic                 ask_full;
  logic                 ask_cancel_hit;

  // Match stage and egress
  logic                 qry_en;
  ob_pkg::ob_match_t    match;
  logic                 rsp_full;
  logic                 rsp_push;
  ob_pkg::ob_rsp_t      rsp_data;

  ob_cmd_latch u_cmd_latch (
      .clk       (clk)
    , .rst_n     (rst_n)
    , .cmd_vld   (cmd_vld)
    , .cmd       (cmd)
    , .consume   (consume)
    , .cmd_pop   (cmd_pop)
    , .latch_vld (latch_vld)
    , .latch     (latch)
  );

  ob_book_table #(.is_bid(1'b1)) u_bid_book (
      .clk          (clk)
    , .rst_n        (rst_n)
    , .insert       (bid_insert)
    , .insert_entry (bid_insert_entry)
    , .pop          (bid_pop)
    , .update       (bid_update)
    , .update_qty   (bid_update_qty)
    , .cancel       (bid_cancel)
    , .cancel_uid   (bid_cancel_uid)
    , .head_vld     (bid_head_vld)
    , .head         (bid_head)
    , .full         (bid_full)
    , .cancel_hit   (bid_cancel_hit)
  );

  ob_book_table #(.is_bid(1'b0)) u_ask_book (
      .clk          (clk)
    , .rst_n        (rst_n)
    , .insert       (ask_insert)
    , .insert_entry (ask_insert_entry)
    , .pop          (ask_pop)
    , .update       (ask_update)
    , .update_qty   (ask_update_qty)
    , .cancel       (ask_cancel)
    , .cancel_uid   (ask_cancel_uid)
    , .head_vld     (ask_head_vld)
    , .head         (ask_head)
    , .full         (ask_full)
    , .cancel_hit   (ask_cancel_hit)
  );

  ob_match u_match (
      .clk     (clk)
    , .rst_n   (rst_n)
    , .qry_en  (qry_en)
    , .bid_vld (bid_head_vld)
    , .ask_vld (ask_head_vld)
    , .bid     (bid_head)
    , .ask     (ask_head)
    , .match   (match)
  );

  ob_cntrl_fsm u_cntrl (
      .clk              (clk)
    , .rst_n            (rst_n)
    , .latch_vld        (latch_vld)
    , .latch            (latch)
    , .consume          (consume)
    , .bid_insert       (bid_insert)
    , .bid_insert_entry (bid_insert_entry)
    , .bid_pop          (bid_pop)
    , .bid_update       (bid_update)
    , .bid_update_qty   (bid_update_qty)
    , .bid_cancel       (bid_cancel)
    , .bid_cancel_uid   (bid_cancel_uid)
    , .bid_head_vld     (bid_head_vld)
    , .bid_head         (bid_head)
    , .bid_full         (bid_full)
    , .bid_cancel_hit   (bid_cancel_hit)
    , .ask_insert       (ask_insert)
    , .ask_insert_entry (ask_insert_entry)
    , .ask_pop          (ask_pop)
    , .ask_update       (ask_update)
    , .ask_update_qty   (ask_update_qty)
    , .ask_cancel       (ask_cancel)
    , .ask_cancel_uid   (ask_cancel_uid)
    , .ask_head_vld     (ask_head_vld)
    , .ask_head         (ask_head)
    , .ask_full         (ask_full)
    , .ask_cancel_hit   (ask_cancel_hit)
    , .qry_en           (qry_en)
    , .match            (match)
    , .rsp_full         (rsp_full)
    , .rsp_push         (rsp_push)
    , .rsp_data         (rsp_data)
  );

  ob_rsp_fifo u_rsp_fifo (
      .clk       (clk)
    , .rst_n     (rst_n)
    , .push      (rsp_push)
    , .push_data (rsp_data)
    , .pop       (rsp_pop)
    , .full      (rsp_full)
    , .vld       (rsp_vld)
    , .head      (rsp)
  );

endmodule

//--- design/ob_rsp_fifo.sv
// Egress queue of order book responses with full flag and head presentation
`timescale 1ns/100ps
`include "ob_config.svh"

module ob_rsp_fifo (
    input  logic            clk
  , input  logic            rst_n
  , input  logic            push
  , input  ob_pkg::ob_rsp_t push_data
  , input  logic            pop
  , output logic            full
  , output logic            vld
  , output ob_pkg::ob_rsp_t head
);

  import ob_pkg::*;

  localparam int DEPTH = `OB_RSP_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  ob_rsp_t        mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic             do_pop;

  // Pop on empty is dropped
  assign do_pop = pop & vld;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign vld  = (count != '0);
  assign full = (count == (PTR_W+1)'(DEPTH));
  assign head = mem[rd_ptr];

endmodule

//--- design/ob_cntrl_fsm.sv
// Order book controller decoding commands and sequencing insert, match and responses
`timescale 1ns/100ps
`include "ob_config.svh"

module ob_cntrl_fsm (
    input  logic                 clk
  , input  logic                 rst_n
  // Command latch
  , input  logic                 latch_vld
  , input  ob_pkg::ob_cmd_t      latch
  , output logic                 consume
  // Bid book
  , output logic                 bid_insert
  , output ob_pkg::ob_entry_t    bid_insert_entry
  , output logic                 bid_pop
  , output logic                 bid_update
  , output logic [`OB_QTY_W-1:0] bid_update_qty
  , output logic                 bid_cancel
  , output logic [`OB_UID_W-1:0] bid_cancel_uid
  , input  logic                 bid_head_vld
  , input  ob_pkg::ob_entry_t    bid_head
  , input  logic                 bid_full
  , input  logic                 bid_cancel_hit
  // Ask book
  , output logic                 ask_insert
  , output ob_pkg::ob_entry_t    ask_insert_entry
  , output logic                 ask_pop
  , output logic                 ask_update
  , output logic [`OB_QTY_W-1:0] ask_update_qty
  , output logic                 ask_cancel
  , output logic [`OB_UID_W-1:0] ask_cancel_uid
  , input  logic                 ask_head_vld
  , input  ob_pkg::ob_entry_t    ask_head
  , input  logic                 ask_full
  , input  logic                 ask_cancel_hit
  // Match stage
  , output logic                 qry_en
  , input  ob_pkg::ob_match_t    match
  // Egress queue
  , input  logic                 rsp_full
  , output logic                 rsp_push
  , output ob_pkg::ob_rsp_t      rsp_data
);

  import ob_pkg::*;

  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    // Sample the heads into the match stage
    ISSUE_QRY   = 2'd1,
    // Act on the registered match
    EXECUTE     = 2'd2,
    // Collect the registered cancel hits
    CANCEL_RESP = 2'd3
  } state_t;

  state_t    state_q;
  state_t    state_d;
  ob_entry_t limit_entry;

  // Book payloads, qualified by their strobes
  assign limit_entry.uid      = latch.uid;
  assign limit_entry.price    = latch.price;
  assign limit_entry.quantity = latch.quantity;
  assign bid_insert_entry     = limit_entry;
  assign ask_insert_entry     = limit_entry;
  assign bid_cancel_uid       = latch.cancel_uid;
  assign ask_cancel_uid       = latch.cancel_uid;
  // Remainder goes to whichever head survives
  assign bid_update_qty       = match.remainder;
  assign ask_update_qty       = match.remainder;

  always_comb begin
    state_d    = state_q;
    consume    = 1'b0;
    bid_insert = 1'b0;
    bid_pop    = 1'b0;
    bid_update = 1'b0;
    bid_cancel = 1'b0;
    ask_insert = 1'b0;
    ask_pop    = 1'b0;
    ask_update = 1'b0;
    ask_cancel = 1'b0;
    qry_en     = 1'b0;
    rsp_push   = 1'b0;
    rsp_data   = '0;

    case (state_q)
      IDLE: begin
        // Whole decode waits on a full egress queue
        if (latch_vld && !rsp_full) begin
          rsp_push        = 1'b1;
          rsp_data.uid    = latch.uid;
          rsp_data.status = ST_OKAY;
          case (latch.opcode)
            OP_NOP: begin
              consume = 1'b1;
            end
            OP_QRY_BID_ASK: begin
              consume = 1'b1;
              // Spread only defined with both sides present
              if (bid_head_vld && ask_head_vld) begin
                rsp_data.result.qrybidask.body.bid = bid_head.price;
                rsp_data.result.qrybidask.body.ask = ask_head.price;
              end else begin
                rsp_data.status = ST_BAD;
              end
            end
            OP_BUY_LIMIT: begin
              if (bid_full) begin
                consume         = 1'b1;
                rsp_data.status = ST_REJECT;
              end else begin
                bid_insert = 1'b1;
                state_d    = ISSUE_QRY;
              end
            end
            OP_SELL_LIMIT: begin
              if (ask_full) begin
                consume         = 1'b1;
                rsp_data.status = ST_REJECT;
              end else begin
                ask_insert = 1'b1;
                state_d    = ISSUE_QRY;
              end
            end
            OP_POP_TOP_BID: begin
              consume = 1'b1;
              if (bid_head_vld) begin
                bid_pop                         = 1'b1;
                rsp_data.result.poptop.uid      = bid_head.uid;
                rsp_data.result.poptop.price    = bid_head.price;
                rsp_data.result.poptop.quantity = bid_head.quantity;
              end else begin
                rsp_data.status = ST_BAD_POP;
              end
            end
            OP_POP_TOP_ASK: begin
              consume = 1'b1;
              if (ask_head_vld) begin
                ask_pop                         = 1'b1;
                rsp_data.result.poptop.uid      = ask_head.uid;
                rsp_data.result.poptop.price    = ask_head.price;
                rsp_data.result.poptop.quantity = ask_head.quantity;
              end else begin
                rsp_data.status = ST_BAD_POP;
              end
            end
            OP_CANCEL: begin
              // Both books search, answer comes next cycle
              rsp_push   = 1'b0;
              bid_cancel = 1'b1;
              ask_cancel = 1'b1;
              state_d    = CANCEL_RESP;
            end
            default: begin
              consume         = 1'b1;
              rsp_data.status = ST_BAD;
            end
          endcase
        end
      end

      ISSUE_QRY: begin
        qry_en  = 1'b1;
        state_d = EXECUTE;
      end

      EXECUTE: begin
        if (!rsp_full) begin
          if (match.trade_vld) begin
            // Remove filled heads, trim the survivor
            bid_pop    = match.bid_consumed;
            ask_pop    = match.ask_consumed;
            bid_update = ~match.bid_consumed;
            ask_update = ~match.ask_consumed;
            // Trade has no originating uid
            rsp_push                            = 1'b1;
            rsp_data.uid                        = '1;
            rsp_data.status                     = ST_OKAY;
            rsp_data.result.trade.body.bid_uid  = match.bid_uid;
            rsp_data.result.trade.body.ask_uid  = match.ask_uid;
            rsp_data.result.trade.body.quantity = match.quantity;
            // Look for a further cross
            state_d = ISSUE_QRY;
          end else begin
            // Book no longer crossed
            consume = 1'b1;
            state_d = IDLE;
          end
        end
      end

      CANCEL_RESP: begin
        // Queue was not full in IDLE and nothing was pushed since
        consume         = 1'b1;
        rsp_push        = 1'b1;
        rsp_data.uid    = latch.uid;
        rsp_data.status = (bid_cancel_hit | ask_cancel_hit) ? ST_CANCEL_HIT
                                                            : ST_CANCEL_MISS;
        state_d         = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- design/ob_match.sv
// Registered compare of best bid against best ask giving the trade decision
`timescale 1ns/100ps

module ob_match (
    input  logic              clk
  , input  logic              rst_n
  , input  logic              qry_en
  , input  logic              bid_vld
  , input  logic              ask_vld
  , input  ob_pkg::ob_entry_t bid
  , input  ob_pkg::ob_entry_t ask
  , output ob_pkg::ob_match_t match
);

  import ob_pkg::*;

  ob_match_t match_nxt;

  always_comb begin
    match_nxt         = '0;
    match_nxt.bid_uid = bid.uid;
    match_nxt.ask_uid = ask.uid;
    // Cross when the bid reaches the ask
    if (bid_vld && ask_vld && (bid.price >= ask.price)) begin
      match_nxt.trade_vld = 1'b1;
      if (bid.quantity < ask.quantity) begin
        // Bid filled, ask keeps the rest
        match_nxt.bid_consumed = 1'b1;
        match_nxt.quantity     = bid.quantity;
        match_nxt.remainder    = ask.quantity - bid.quantity;
      end else if (ask.quantity < bid.quantity) begin
        // Ask filled, bid keeps the rest
        match_nxt.ask_consumed = 1'b1;
        match_nxt.quantity     = ask.quantity;
        match_nxt.remainder    = bid.quantity - ask.quantity;
      end else begin
        // Exact fill on both sides
        match_nxt.bid_consumed = 1'b1;
        match_nxt.ask_consumed = 1'b1;
        match_nxt.quantity     = bid.quantity;
      end
    end
  end

  // Cuts the compare and subtract path from the controller
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      match <= '0;
    end else if (qry_en) begin
      match <= match_nxt;
    end
  end

endmodule

//--- design/ob_book_table.sv
// Sorted book of resting orders with insert, head pop, head update and cancel
`timescale 1ns/100ps
`include "ob_config.svh"

module ob_book_table #(
  // 1 keeps highest price first, 0 keeps lowest price first
  parameter bit is_bid = 1'b1
) (
    input  logic                  clk
  , input  logic                  rst_n
  , input  logic                  insert
  , input  ob_pkg::ob_entry_t     insert_entry
  , input  logic                  pop
  , input  logic                  update
  , input  logic [`OB_QTY_W-1:0]  update_qty
  , input  logic                  cancel
  , input  logic [`OB_UID_W-1:0]  cancel_uid
  , output logic                  head_vld
  , output ob_pkg::ob_entry_t     head
  , output logic                  full
  , output logic                  cancel_hit
);

  import ob_pkg::*;

  localparam int DEPTH = `OB_BOOK_DEPTH;

  // Slot 0 is the best order, valid slots are contiguous from 0
  ob_entry_t        tbl     [DEPTH];
  ob_entry_t        tbl_nxt [DEPTH];
  logic [DEPTH-1:0] vld;
  logic [DEPTH-1:0] vld_nxt;

  // New order lands at or before this slot
  logic [DEPTH-1:0] place;
  // Cancel uid match per slot
  logic [DEPTH-1:0] hit;
  // Hit slot and all slots behind it
  logic [DEPTH-1:0] after;
  // Neighbour ahead, or the new order at the insertion point
  ob_entry_t        ahead  [DEPTH];
  // Neighbour behind, to close a gap
  ob_entry_t        behind [DEPTH];

  // Strictly better only, so equal prices keep arrival order
  function automatic logic outranks(input logic [`OB_PRICE_W-1:0] a,
                                    input logic [`OB_PRICE_W-1:0] b);
    return is_bid ? (a > b) : (a < b);
  endfunction

  for (genvar g = 0; g < DEPTH; g++) begin : g_slot
    assign place[g] = ~vld[g] | outranks(insert_entry.price, tbl[g].price);
    assign hit[g]   = vld[g] & (tbl[g].uid == cancel_uid);
    if (g == 0) begin : g_first
      assign ahead[g] = insert_entry;
      assign after[g] = hit[g];
    end else begin : g_rest
      assign ahead[g] = place[g-1] ? tbl[g-1] : insert_entry;
      assign after[g] = after[g-1] | hit[g];
    end
    if (g == DEPTH-1) begin : g_last
      assign behind[g] = tbl[g];
    end else begin : g_inner
      assign behind[g] = tbl[g+1];
    end
  end

  // One operation per cycle, the controller never overlaps them
  always_comb begin
    tbl_nxt = tbl;
    vld_nxt = vld;
    if (insert) begin
      // Shift the tail back by one from the insertion point
      for (int i = 0; i < DEPTH; i++) begin
        if (place[i]) begin
          tbl_nxt[i] = ahead[i];
        end
      end
      vld_nxt = {vld[DEPTH-2:0], 1'b1};
    end else if (pop) begin
      tbl_nxt = behind;
      vld_nxt = vld >> 1;
    end else if (update) begin
      tbl_nxt[0].quantity = update_qty;
    end else if (cancel && |hit) begin
      // Close the gap left by the cancelled order
      for (int i = 0; i < DEPTH; i++) begin
        if (after[i]) begin
          tbl_nxt[i] = behind[i];
        end
      end
      vld_nxt = vld >> 1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld        <= '0;
      cancel_hit <= 1'b0;
    end else begin
      vld        <= vld_nxt;
      cancel_hit <= cancel & (|hit);
    end
  end

  always_ff @(posedge clk) begin
    tbl <= tbl_nxt;
  end

  assign head_vld = vld[0];
  assign head     = tbl[0];
  assign full     = vld[DEPTH-1];

endmodule

//--- design/ob_cmd_latch.sv
// Command latch holding one ingress command until the controller consumes it
`timescale 1ns/100ps

module ob_cmd_latch (
    input  logic            clk
  , input  logic            rst_n
  // Ingress level with pop strobe
  , input  logic            cmd_vld
  , input  ob_pkg::ob_cmd_t cmd
  , output logic            cmd_pop
  // Toward the controller
  , input  logic            consume
  , output logic            latch_vld
  , output ob_pkg::ob_cmd_t latch
);

  import ob_pkg::*;

  logic    vld_q;
  ob_cmd_t cmd_q;

  // Fetch when empty or emptied this cycle
  assign cmd_pop = cmd_vld & (consume | ~vld_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else if (cmd_pop) begin
      vld_q <= 1'b1;
    end else if (consume) begin
      vld_q <= 1'b0;
    end
  end

  // Command payload, loaded on each fetch
  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      cmd_q <= cmd;
    end
  end

  assign latch_vld = vld_q;
  assign latch     = cmd_q;

endmodule

//--- design/ob_pkg.sv
// Order book package with opcodes, status codes, commands and responses
`include "ob_config.svh"

package ob_pkg;

  // Command opcodes
  typedef enum logic [3:0] {
    OP_NOP          = 4'd0,
    OP_QRY_BID_ASK  = 4'd1,
    OP_BUY_LIMIT    = 4'd2,
    OP_SELL_LIMIT   = 4'd3,
    OP_POP_TOP_BID  = 4'd4,
    OP_POP_TOP_ASK  = 4'd5,
    OP_CANCEL       = 4'd6
  } ob_opcode_t;

  // Response status
  typedef enum logic [2:0] {
    ST_OKAY        = 3'd0,
    ST_BAD         = 3'd1,
    ST_BAD_POP     = 3'd2,
    ST_REJECT      = 3'd3,
    ST_CANCEL_HIT  = 3'd4,
    ST_CANCEL_MISS = 3'd5
  } ob_status_t;

  typedef struct packed {
    ob_opcode_t             opcode;
    logic [`OB_UID_W-1:0]   uid;
    logic [`OB_PRICE_W-1:0] price;
    logic [`OB_QTY_W-1:0]   quantity;
    // Target of a cancel
    logic [`OB_UID_W-1:0]   cancel_uid;
  } ob_cmd_t;

  // Resting order in a book
  typedef struct packed {
    logic [`OB_UID_W-1:0]   uid;
    logic [`OB_PRICE_W-1:0] price;
    logic [`OB_QTY_W-1:0]   quantity;
  } ob_entry_t;

  typedef struct packed {
    logic [`OB_PRICE_W-1:0] bid;
    logic [`OB_PRICE_W-1:0] ask;
  } ob_qrybidask_t;

  typedef struct packed {
    logic [`OB_UID_W-1:0]   uid;
    logic [`OB_PRICE_W-1:0] price;
    logic [`OB_QTY_W-1:0]   quantity;
  } ob_poptop_t;

  typedef struct packed {
    logic [`OB_UID_W-1:0] bid_uid;
    logic [`OB_UID_W-1:0] ask_uid;
    logic [`OB_QTY_W-1:0] quantity;
  } ob_trade_t;

  // Result word is as wide as the widest member
  localparam int OB_RESULT_W = $bits(ob_poptop_t);

  // Narrow members sit in the low bits with zero padding above
  typedef struct packed {
    logic [OB_RESULT_W-$bits(ob_qrybidask_t)-1:0] pad;
    ob_qrybidask_t                                body;
  } ob_qrybidask_pad_t;

  typedef struct packed {
    logic [OB_RESULT_W-$bits(ob_trade_t)-1:0] pad;
    ob_trade_t                                body;
  } ob_trade_pad_t;

  // One result word, decoded by the opcode of the response
  typedef union packed {
    ob_qrybidask_pad_t qrybidask;
    ob_poptop_t        poptop;
    ob_trade_pad_t     trade;
  } ob_result_u;

  typedef struct packed {
    logic [`OB_UID_W-1:0] uid;
    ob_status_t           status;
    ob_result_u           result;
  } ob_rsp_t;

  // Registered outcome of the head compare
  typedef struct packed {
    logic                 trade_vld;
    logic                 bid_consumed;
    logic                 ask_consumed;
    logic [`OB_UID_W-1:0] bid_uid;
    logic [`OB_UID_W-1:0] ask_uid;
    logic [`OB_QTY_W-1:0] quantity;
    // Left on the surviving head
    logic [`OB_QTY_W-1:0] remainder;
  } ob_match_t;

endpackage

//--- design/ob_config.svh
// Order book configuration with field widths and storage depths
`ifndef OB_CONFIG_SVH
`define OB_CONFIG_SVH

// Order uid width
`define OB_UID_W 8

// Plain binary price
`define OB_PRICE_W 16

// Share quantity
`define OB_QTY_W 12

// Resting orders per side
`define OB_BOOK_DEPTH 4

// Egress response slots
`define OB_RSP_DEPTH 4

`endif
